// File: src/dma_pkg.sv
`default_nettype none

package dma_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        IDLE = 2'd0,    // waiting for a command.
        RUN  = 2'd1,    // bursts out, words draining.
        DONE = 2'd2     // one-cycle completion pulse.
    } dma_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // default sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DEF_ADDR_W    = 16;  // word address.
    localparam int DEF_LEN_W     = 12;  // command length in words.
    localparam int DEF_OLEN      = 3;   // max burst is 2**OLEN words.
    localparam int DEF_DATA_W    = 32;

    // must hold at least one full burst.
    localparam int DEF_BUF_DEPTH = 16;

endpackage

`default_nettype wire

// File: src/dma_cmd_split.sv
`timescale 1ns/100ps
`default_nettype none

module dma_cmd_split import dma_pkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int LEN_W  = DEF_LEN_W,     // must exceed OLEN.
    parameter int OLEN   = DEF_OLEN
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // command side
    input  wire logic              in_valid,
    input  wire logic [ADDR_W-1:0] in_addr,
    input  wire logic [LEN_W-1:0]  in_len,
    output logic                   in_ready,

    // burst side
    input  wire logic              out_ready,
    output logic                   out_valid,
    output logic      [ADDR_W-1:0] out_addr,
    output logic      [OLEN:0]     out_len,
    output logic                   out_last
);

    localparam logic [OLEN:0] BURST_MAX = (OLEN+1)'(1) << OLEN;

    logic              split_valid;
    logic [ADDR_W-1:0] split_addr;
    logic [LEN_W-1:0]  split_len;   // words left in the command.
    logic [OLEN:0]     split_inc;   // words up to the next boundary.
    logic              split_last;
    logic              load;
    logic              advance;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_ready = !split_valid;
    assign load     = in_valid && !split_valid;
    assign advance  = split_valid && out_ready;

    // remainder fits inside the current aligned window.
    assign split_last = (split_len <= LEN_W'(split_inc));

    always_ff @(posedge clk) begin
        if (rst) begin
            split_valid <= 1'b0;
        end else if (load) begin
            split_valid <= 1'b1;
        end else if (advance && split_last) begin
            split_valid <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // burst walk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (load) begin
            split_addr <= in_addr;
            split_len  <= in_len;
            split_inc  <= BURST_MAX - {1'b0, in_addr[OLEN-1:0]};  // partial first burst.
        end else if (advance) begin
            // next aligned window.
            split_addr <= {split_addr[ADDR_W-1:OLEN] + 1'b1, {OLEN{1'b0}}};
            split_len  <= split_len - LEN_W'(split_inc);
            split_inc  <= BURST_MAX;
        end
    end

    assign out_valid = split_valid;
    assign out_addr  = split_addr;
    assign out_len   = split_last ? split_len[OLEN:0] : split_inc;
    assign out_last  = split_last;

endmodule

`default_nettype wire

// File: src/dma_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module dma_credit_counter import dma_pkg::*; #(
    parameter int BUF_DEPTH = DEF_BUF_DEPTH,
    parameter int OLEN      = DEF_OLEN
) (
    input  wire logic          clk,
    input  wire logic          rst,

    input  wire logic          take,       // burst issued.
    input  wire logic [OLEN:0] take_len,   // pending burst length.
    input  wire logic          give,       // word left the buffer.

    output logic               enough
);

    // wide enough for BUF_DEPTH itself, and so for any burst length.
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] need;
    logic [CNT_W-1:0] take_amt;
    logic [CNT_W-1:0] give_amt;

    assign need     = CNT_W'(take_len);
    assign take_amt = take ? need : '0;
    assign give_amt = CNT_W'(give);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // free word count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt <= CNT_W'(BUF_DEPTH);
        end else begin
            free_cnt <= free_cnt - take_amt + give_amt;  // both may hit at once.
        end
    end

    // whole burst must fit.
    assign enough = (free_cnt >= need);

endmodule

`default_nettype wire

// File: src/dma_read_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dma_read_ctrl import dma_pkg::*; #(
    parameter int LEN_W = DEF_LEN_W
) (
    input  wire logic             clk,
    input  wire logic             rst,

    // command port
    input  wire logic             cmd_valid,
    input  wire logic [LEN_W-1:0] cmd_len,
    output logic                  cmd_ready,

    // splitter and credits
    input  wire logic             split_valid,
    input  wire logic             enough,
    output logic                  split_start,

    // burst request port
    input  wire logic             rd_req_ready,
    output logic                  rd_req_valid,
    output logic                  issue,

    // output side
    input  wire logic             pop,
    output logic                  done
);

    dma_state_e       state;
    dma_state_e       state_nxt;
    logic [LEN_W-1:0] remain;       // words still to leave the engine.
    logic             last_pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign cmd_ready   = (state == IDLE);
    assign split_start = cmd_valid && cmd_ready;

    // credits gate the burst.
    assign rd_req_valid = split_valid && (state == RUN) && enough;
    assign issue        = rd_req_valid && rd_req_ready;

    assign last_pop = pop && (remain == LEN_W'(1));
    assign done     = (state == DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (split_start) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (last_pop) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // remaining word counter.
    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else if (split_start) begin
            remain <= cmd_len;
        end else if (pop && (state == RUN)) begin
            remain <= remain - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/dma_read_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module dma_read_buffer import dma_pkg::*; #(
    parameter int DATA_W    = DEF_DATA_W,
    parameter int BUF_DEPTH = DEF_BUF_DEPTH
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // memory return, never stalled
    input  wire logic              wr_en,
    input  wire logic [DATA_W-1:0] wr_data,

    // output stream
    input  wire logic              out_ready,
    output logic                   out_valid,
    output logic      [DATA_W-1:0] out_data,
    output logic                   pop
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [DATA_W-1:0] mem [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill;

    // wrap at BUF_DEPTH, which need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // credits keep a write from landing on a full buffer.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign out_valid = (fill != '0);    // word readable the cycle after its write.
    assign out_data  = mem[rd_ptr];
    assign pop       = out_valid && out_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and fill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill <= fill + CNT_W'(wr_en) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// File: src/dma_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module dma_read_engine import dma_pkg::*; #(
    parameter int ADDR_W    = DEF_ADDR_W,
    parameter int LEN_W     = DEF_LEN_W,
    parameter int OLEN      = DEF_OLEN,
    parameter int DATA_W    = DEF_DATA_W,
    parameter int BUF_DEPTH = DEF_BUF_DEPTH
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // command port
    input  wire logic              cmd_valid,
    input  wire logic [ADDR_W-1:0] cmd_addr,
    input  wire logic [LEN_W-1:0]  cmd_len,
    output logic                   cmd_ready,

    // burst request port
    input  wire logic              rd_req_ready,
    output logic                   rd_req_valid,
    output logic      [ADDR_W-1:0] rd_req_addr,
    output logic      [OLEN:0]     rd_req_len,

    // data return without back-pressure
    input  wire logic              rd_data_valid,
    input  wire logic [DATA_W-1:0] rd_data,

    // output stream
    input  wire logic              out_ready,
    output logic                   out_valid,
    output logic      [DATA_W-1:0] out_data,

    output logic                   done
);

    logic split_start;
    logic split_valid;
    logic enough;
    logic issue;
    logic pop;

    dma_cmd_split #(
        .ADDR_W (ADDR_W),
        .LEN_W  (LEN_W),
        .OLEN   (OLEN)
    ) u_cmd_split (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (split_start),
        .in_addr   (cmd_addr),
        .in_len    (cmd_len),
        .in_ready  (),
        .out_ready (issue),
        .out_valid (split_valid),
        .out_addr  (rd_req_addr),
        .out_len   (rd_req_len),
        .out_last  ()
    );

    dma_credit_counter #(
        .BUF_DEPTH (BUF_DEPTH),
        .OLEN      (OLEN)
    ) u_credit_counter (
        .clk      (clk),
        .rst      (rst),
        .take     (issue),
        .take_len (rd_req_len),
        .give     (pop),
        .enough   (enough)
    );

    dma_read_ctrl #(
        .LEN_W (LEN_W)
    ) u_read_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_len      (cmd_len),
        .cmd_ready    (cmd_ready),
        .split_valid  (split_valid),
        .enough       (enough),
        .split_start  (split_start),
        .rd_req_ready (rd_req_ready),
        .rd_req_valid (rd_req_valid),
        .issue        (issue),
        .pop          (pop),
        .done         (done)
    );

    dma_read_buffer #(
        .DATA_W    (DATA_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_read_buffer (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (rd_data_valid),
        .wr_data   (rd_data),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .pop       (pop)
    );

endmodule

`default_nettype wire

// File: verification/dma_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dma_mem_model #(
    parameter int ADDR_W = 16,
    parameter int OLEN   = 3,
    parameter int DATA_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // burst requests
    input  wire logic              rd_req_valid,
    input  wire logic [ADDR_W-1:0] rd_req_addr,
    input  wire logic [OLEN:0]     rd_req_len,
    output logic                   rd_req_ready,

    // data return, never stalled
    output logic                   rd_data_valid,
    output logic      [DATA_W-1:0] rd_data
);

    int unsigned       cycle;
    logic [ADDR_W-1:0] addr_q[$];   // words still to return.
    int unsigned       due_q[$];    // earliest return cycle per word.

    // upper half ~a, lower half a.
    function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        logic [15:0] lo;
        lo = 16'(a);
        return DATA_W'({~lo, lo});
    endfunction

    initial begin
        cycle         = 0;
        rd_req_ready  = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
    end

    always @(posedge clk) begin : serve
        int unsigned delay;
        if (rst) begin
            cycle = 0;
            addr_q.delete();
            due_q.delete();
            rd_req_ready  <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            cycle = cycle + 1;
            rd_req_ready <= ($urandom_range(3) != 0);  // ready about 3 cycles in 4.
            if (rd_req_valid && rd_req_ready) begin
                delay = $urandom_range(6, 1);
                for (int i = 0; i < int'(rd_req_len); i++) begin
                    addr_q.push_back(rd_req_addr + ADDR_W'(i));
                    due_q.push_back(cycle + delay);
                end
            end
            // one word per cycle, request order.
            if (addr_q.size() > 0 && due_q[0] <= cycle) begin
                rd_data_valid <= 1'b1;
                rd_data       <= word_at(addr_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                rd_data_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_dma_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dma_read_engine import dma_pkg::*; ();

    localparam int ADDR_W        = DEF_ADDR_W;
    localparam int LEN_W         = DEF_LEN_W;
    localparam int OLEN          = DEF_OLEN;
    localparam int DATA_W        = DEF_DATA_W;
    localparam int BURST_MAX     = 1 << OLEN;
    localparam int NUM_TESTS     = 4;
    localparam int CMDS_PER_TEST = 12;
    localparam int NUM_CMDS      = NUM_TESTS * CMDS_PER_TEST;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              cmd_valid;
    logic [ADDR_W-1:0] cmd_addr;
    logic [LEN_W-1:0]  cmd_len;
    logic              cmd_ready;
    logic              rd_req_valid;
    logic              rd_req_ready;
    logic [ADDR_W-1:0] rd_req_addr;
    logic [OLEN:0]     rd_req_len;
    logic              rd_data_valid;
    logic [DATA_W-1:0] rd_data;
    logic              out_ready;
    logic              out_valid;
    logic [DATA_W-1:0] out_data;
    logic              done;

    // reference state kept beside the DUT.
    logic              rst_d = 1'b0;
    logic              busy = 1'b0;
    int                words_left = 0;
    int                cur_len = 0;
    int                burst_sum = 0;
    logic [ADDR_W-1:0] next_addr = '0;
    int                issued_words = 0;
    int                popped_words = 0;
    int                done_cnt = 0;
    int                fail_cnt = 0;
    int                cycle_cnt = 0;
    int                timeout_limit = 1000;
    int                duty = 100;
    logic [ADDR_W-1:0] cmd_a [NUM_CMDS];
    int                cmd_l [NUM_CMDS];
    logic [DATA_W-1:0] sb_q[$];        // expected output words.
    int                duties [NUM_TESTS] = '{100, 60, 25, 10};

    dma_read_engine #(
        .ADDR_W    (ADDR_W),
        .LEN_W     (LEN_W),
        .OLEN      (OLEN),
        .DATA_W    (DATA_W),
        .BUF_DEPTH (DEF_BUF_DEPTH)
    ) u_dma_read_engine (
        .clk (clk), .rst (rst),
        .cmd_valid (cmd_valid), .cmd_addr (cmd_addr), .cmd_len (cmd_len), .cmd_ready (cmd_ready),
        .rd_req_ready (rd_req_ready), .rd_req_valid (rd_req_valid),
        .rd_req_addr (rd_req_addr), .rd_req_len (rd_req_len),
        .rd_data_valid (rd_data_valid), .rd_data (rd_data),
        .out_ready (out_ready), .out_valid (out_valid), .out_data (out_data),
        .done (done)
    );

    dma_mem_model #(
        .ADDR_W (ADDR_W),
        .OLEN   (OLEN),
        .DATA_W (DATA_W)
    ) u_mem (
        .clk (clk), .rst (rst),
        .rd_req_valid (rd_req_valid), .rd_req_addr (rd_req_addr), .rd_req_len (rd_req_len),
        .rd_req_ready (rd_req_ready),
        .rd_data_valid (rd_data_valid), .rd_data (rd_data)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        return DATA_W'({~a[15:0], a[15:0]});
    endfunction

    task automatic log_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        fail_cnt++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        fail_cnt++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge clk) rst_d |-> (!rd_req_valid && !out_valid && !done && cmd_ready))
        else note_failure("outputs not at their reset values");
    assert property (@(posedge clk) disable iff (rst)
        rd_req_valid |-> (rd_req_len >= 1 && int'(rd_req_len) <= BURST_MAX))
        else note_failure("burst length out of range");
    assert property (@(posedge clk) disable iff (rst)
        rd_req_valid |-> (int'(rd_req_addr[OLEN-1:0]) + int'(rd_req_len) <= BURST_MAX))
        else note_failure("burst crosses an aligned boundary");
    assert property (@(posedge clk) disable iff (rst) rd_req_valid |-> (rd_req_addr == next_addr))
        else log_mismatch($sformatf("burst addr %h, expected %h",
                                    $sampled(rd_req_addr), $sampled(next_addr)));
    assert property (@(posedge clk) disable iff (rst)
        (issued_words - popped_words) <= DEF_BUF_DEPTH)
        else note_failure("words in flight exceed the buffer depth");
    assert property (@(posedge clk) disable iff (rst)
        (busy && out_valid && out_ready && words_left == 1) |=> done)
        else note_failure("done missing after the final output word");
    assert property (@(posedge clk) disable iff (rst)
        done |-> (busy && words_left == 0 && burst_sum == cur_len))
        else note_failure("done early, or burst lengths do not add up");
    assert property (@(posedge clk) disable iff (rst) done |=> (!done && cmd_ready))
        else note_failure("done longer than one cycle or engine not ready after it");
    assert property (@(posedge clk) disable iff (rst) busy |-> !cmd_ready)
        else note_failure("cmd_ready high while a command is running");
    assert property (@(posedge clk) disable iff (rst) !busy |-> !rd_req_valid)
        else note_failure("burst requested between commands");
    assert property (@(posedge clk) disable iff (rst) (rd_req_valid && !rd_req_ready) |=>
        (rd_req_valid && $stable(rd_req_addr) && $stable(rd_req_len)))
        else note_failure("pending burst changed under back-pressure");

    // output data against the scoreboard.
    always @(posedge clk) begin : check_data
        logic [DATA_W-1:0] exp_word;
        if (!rst && out_valid && out_ready) begin
            if (sb_q.size() == 0) begin
                note_failure("output word with nothing expected");
            end else begin
                exp_word = sb_q.pop_front();
                assert (out_data == exp_word)
                    else log_mismatch($sformatf("out_data %h, expected %h", out_data, exp_word));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        rst_d <= rst;
        if (rst) begin
            busy <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                busy       <= 1'b1;
                words_left <= int'(cmd_len);
                cur_len    <= int'(cmd_len);
                burst_sum  <= 0;
                next_addr  <= cmd_addr;
            end
            if (rd_req_valid && rd_req_ready) begin
                issued_words <= issued_words + int'(rd_req_len);
                burst_sum    <= burst_sum + int'(rd_req_len);
                next_addr    <= next_addr + ADDR_W'(rd_req_len);
            end
            if (out_valid && out_ready) begin
                popped_words <= popped_words + 1;
                words_left   <= words_left - 1;
            end
            if (done) begin
                busy     <= 1'b0;
                done_cnt <= done_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        out_ready <= ($urandom_range(99) < duty);
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_command(input logic [ADDR_W-1:0] a, input int len);
        for (int k = 0; k < len; k++) begin
            sb_q.push_back(word_at(a + ADDR_W'(k)));
        end
        cmd_valid <= 1'b1;
        cmd_addr  <= a;
        cmd_len   <= LEN_W'(len);
        do @(posedge clk); while (!cmd_ready);
        cmd_valid <= 1'b0;
        do @(posedge clk); while (!done);
        repeat ($urandom_range(3)) @(posedge clk);
    endtask

    task automatic run_test(input int t);
        int fails_before;
        int words;
        fails_before = fail_cnt;
        words = 0;
        duty <= duties[t];
        for (int i = 0; i < CMDS_PER_TEST; i++) begin
            send_command(cmd_a[t*CMDS_PER_TEST+i], cmd_l[t*CMDS_PER_TEST+i]);
            words += cmd_l[t*CMDS_PER_TEST+i];
        end
        $display("test %0d: out_ready duty %0d%%, %0d commands, %0d words, %0d failures",
                 t, duties[t], CMDS_PER_TEST, words, fail_cnt - fails_before);
    endtask

    initial begin : main
        int total_words;
        void'($urandom(90));
        cmd_valid = 1'b0;
        cmd_addr  = '0;
        cmd_len   = '0;
        out_ready = 1'b0;
        total_words = 0;
        for (int i = 0; i < NUM_CMDS; i++) begin
            cmd_a[i] = ADDR_W'($urandom_range(16'hffff));
            cmd_l[i] = $urandom_range(40, 1);
            total_words += cmd_l[i];
        end
        timeout_limit = total_words * 20 + 1000;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clk);

        if (done_cnt != NUM_CMDS) begin
            note_failure($sformatf("%0d done pulses for %0d commands", done_cnt, NUM_CMDS));
        end
        if (sb_q.size() != 0) begin
            note_failure($sformatf("%0d expected words never came out", sb_q.size()));
        end
        $display("summary: %0d tests, %0d commands, %0d words, %0d failures",
                 NUM_TESTS, NUM_CMDS, total_words, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/dma_pkg.sv
src/dma_cmd_split.sv
src/dma_credit_counter.sv
src/dma_read_ctrl.sv
src/dma_read_buffer.sv
src/dma_read_engine.sv
verification/dma_mem_model.sv
verification/tb_dma_read_engine.sv
